//--- build.f
common/mips_pkg.sv
execute/ex_stage.sv
memory/mem_stage.sv
memory/data_memory.sv
logic/reg_file.sv
logic/mips_backend.sv
verif/mips_backend_assert.sv
verif/tb_mips_backend.sv

//--- verif/tb_mips_backend.sv
// drives one instruction then three bubbles; memory ops use r0 as base so addresses stay in range
`timescale 1ns/1ps

module tb_mips_backend;

	localparam int CLK_PERIOD      = 40;
	localparam int RESET_CYCLES    = 16;
	localparam int NUM_INSTR       = 300;
	// reset plus four cycles per instruction plus some slack
	localparam int WATCHDOG_CYCLES = RESET_CYCLES + NUM_INSTR * 4 + 20;

	logic             i_clk;
	logic             i_rst_n;
	mips_pkg::id_ex_t i_issue;
	logic             o_pc_src;
	logic [31:0]      o_jb_pc;
	logic             o_wb_en;
	logic [4:0]       o_wb_addr;
	logic [31:0]      o_wb_data;

	// stimulus state
	logic [31:0] lfsr;
	logic        stored [mips_pkg::DMEM_WORDS];
	int          stored_words [$];

	mips_backend dut0
	(
		.i_clk     (i_clk),
		.i_rst_n   (i_rst_n),
		.i_issue   (i_issue),
		.o_pc_src  (o_pc_src),
		.o_jb_pc   (o_jb_pc),
		.o_wb_en   (o_wb_en),
		.o_wb_addr (o_wb_addr),
		.o_wb_data (o_wb_data)
	);

	// checker on the top-level ports
	bind mips_backend mips_backend_assert chk0
	(
		.i_clk     (i_clk),
		.i_rst_n   (i_rst_n),
		.i_issue   (i_issue),
		.o_pc_src  (o_pc_src),
		.o_jb_pc   (o_jb_pc),
		.o_wb_en   (o_wb_en),
		.o_wb_addr (o_wb_addr),
		.o_wb_data (o_wb_data)
	);

	always #(CLK_PERIOD / 2) i_clk = ~i_clk;

	// ======================================
	// random sources
	// ======================================

	// fibonacci lfsr with taps 32 22 2 1
	// one step per bit taken
	function automatic logic [31:0] take_bits(input int n);
		logic [31:0] val;
		logic        fb;
		int          k;
		val = '0;
		for (k = 0; k < n; k++)
		begin
			fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
			lfsr = {lfsr[30:0], fb};
			val  = {val[30:0], fb};
		end
		return val;
	endfunction

	function automatic logic [31:0] sext16(input logic [31:0] v);
		return {{16{v[15]}}, v[15:0]};
	endfunction

	function automatic mips_pkg::alu_op_e alu_from_sel(input int sel);
		case (sel)
			0:       return mips_pkg::ALU_ADD;
			1:       return mips_pkg::ALU_SUB;
			2:       return mips_pkg::ALU_AND;
			3:       return mips_pkg::ALU_OR;
			default: return mips_pkg::ALU_SLT;
		endcase
	endfunction

	// ======================================
	// instruction builder
	// ======================================

	function automatic mips_pkg::id_ex_t next_instr(input int idx);
		mips_pkg::id_ex_t ins;
		logic [2:0]       kind;
		int               word;
		ins          = '0;
		ins.pc_plus4 = take_bits(30) << 2;
		// first 31 seed r1..r31 from r0
		if (idx < 31)
		begin
			ins.ctl.regwrite = 1'b1;
			ins.ctl.alu_src  = 1'b1;
			ins.ctl.alu_op   = mips_pkg::ALU_ADD;
			ins.rd_addr      = 5'(idx + 1);
			ins.imm          = sext16(take_bits(16));
			return ins;
		end
		kind = 3'(take_bits(3));
		// nothing to load yet
		if (kind == 3'd5 && stored_words.size() == 0)
		begin
			kind = 3'd4;
		end
		case (kind)
			// r-type where rd may be r0
			3'd0, 3'd1, 3'd2:
			begin
				ins.ctl.regwrite = 1'b1;
				ins.ctl.alu_op   = alu_from_sel(int'(take_bits(3) % 5));
				ins.rs_addr      = 5'(take_bits(5));
				ins.rt_addr      = 5'(take_bits(5));
				ins.rd_addr      = 5'(take_bits(5));
			end
			// i-type
			3'd3:
			begin
				ins.ctl.regwrite = 1'b1;
				ins.ctl.alu_src  = 1'b1;
				ins.ctl.alu_op   = alu_from_sel(int'(take_bits(3) % 5));
				ins.rs_addr      = 5'(take_bits(5));
				ins.rd_addr      = 5'(take_bits(5));
				ins.imm          = sext16(take_bits(16));
			end
			// store word
			3'd4:
			begin
				word             = int'(take_bits(6));
				ins.ctl.memwrite = 1'b1;
				ins.ctl.alu_src  = 1'b1;
				ins.ctl.alu_op   = mips_pkg::ALU_ADD;
				ins.rt_addr      = 5'(take_bits(5));
				ins.imm          = word * 4;
				if (!stored[word])
				begin
					stored[word] = 1'b1;
					stored_words.push_back(word);
				end
			end
			// load from a stored word only
			3'd5:
			begin
				word             = stored_words[take_bits(16) % stored_words.size()];
				ins.ctl.regwrite = 1'b1;
				ins.ctl.memtoreg = 1'b1;
				ins.ctl.memread  = 1'b1;
				ins.ctl.alu_src  = 1'b1;
				ins.ctl.alu_op   = mips_pkg::ALU_ADD;
				ins.rd_addr      = 5'(take_bits(5));
				ins.imm          = word * 4;
			end
			// beq with half of them on equal registers
			3'd6:
			begin
				ins.ctl.branch = 1'b1;
				ins.ctl.alu_op = mips_pkg::ALU_SUB;
				ins.rs_addr    = 5'(take_bits(5));
				ins.rt_addr    = take_bits(1) ? ins.rs_addr : 5'(take_bits(5));
				ins.imm        = sext16(take_bits(16));
			end
			// jr
			default:
			begin
				ins.ctl.jumpreg = 1'b1;
				ins.ctl.alu_op  = mips_pkg::ALU_PASS_A;
				ins.rs_addr     = 5'(take_bits(5));
			end
		endcase
		return ins;
	endfunction

	// drive at a falling edge and follow with three bubbles
	task automatic issue_instr(input mips_pkg::id_ex_t ins);
		i_issue = ins;
		repeat (3)
		begin
			@(negedge i_clk);
			i_issue = '0;
		end
		@(negedge i_clk);
	endtask

	// ======================================
	// run control
	// ======================================

	initial
	begin : stimulus
		int n;
		i_clk   = 1'b0;
		i_rst_n = 1'b0;
		i_issue = '0;
		// live jr with a register write during reset must not reach the outputs
		i_issue.ctl.regwrite = 1'b1;
		i_issue.ctl.jumpreg  = 1'b1;
		i_issue.ctl.alu_op   = mips_pkg::ALU_PASS_A;
		i_issue.rd_addr      = 5'd1;
		lfsr    = 32'h4f14;
		for (n = 0; n < mips_pkg::DMEM_WORDS; n++)
		begin
			stored[n] = 1'b0;
		end
		repeat (RESET_CYCLES) @(negedge i_clk);
		i_rst_n = 1'b1;
		i_issue = '0;
		repeat (2) @(negedge i_clk);
		for (n = 0; n < NUM_INSTR; n++)
		begin
			issue_instr(next_instr(n));
		end
		if (dut0.chk0.error_count == 0)
		begin
			$display("Test passed");
			$finish;
		end
		else
		begin
			$display("Test failed");
			$fatal(1, "checker reported %0d assertion failures", dut0.chk0.error_count);
		end
	end

	// stop at the first checker failure
	always @(negedge i_clk)
	begin
		if (dut0.chk0.error_count != 0)
		begin
			$display("Test failed");
			$fatal(1, "an assertion in the bound checker failed");
		end
	end

	initial
	begin
		#(WATCHDOG_CYCLES * CLK_PERIOD);
		$display("Test failed");
		$fatal(1, "timeout: stimulus did not finish within %0d cycles", WATCHDOG_CYCLES);
	end

endmodule

//--- verif/mips_backend_assert.sv
// sees top-level ports only; valid only with three bubbles per instruction and loads of stored words
`timescale 1ns/1ps

module mips_backend_assert
(
	input logic             i_clk,
	input logic             i_rst_n,
	input mips_pkg::id_ex_t i_issue,
	input logic             o_pc_src,
	input logic [31:0]      o_jb_pc,
	input logic             o_wb_en,
	input logic [4:0]       o_wb_addr,
	input logic [31:0]      o_wb_data
);

	// ======================================
	// shadow state
	// ======================================

	logic [31:0] sregs [32];
	logic [31:0] smem [mips_pkg::DMEM_WORDS];

	logic [31:0] rs_val;
	logic [31:0] rt_val;
	logic [31:0] op_b;
	logic [31:0] exp_alu;
	logic [31:0] exp_load;
	logic [31:0] mem_ea;
	logic [31:0] br_target;
	logic [mips_pkg::DMEM_AW-1:0] exp_word;
	logic        br_equal;
	logic        wr_issue;
	logic        alu_wr;
	logic        load_wr;
	logic        reset_window;

	// read by the testbench
	int unsigned error_count = 0;
	// edges seen with reset low, then edges since release
	int unsigned low_edges = 0;
	int unsigned post_edges = 0;

	// reference alu, per opcode definition
	function automatic logic [31:0] alu_model(input mips_pkg::alu_op_e op,
		input logic [31:0] a, input logic [31:0] b);
		case (op)
			mips_pkg::ALU_ADD:    return a + b;
			mips_pkg::ALU_SUB:    return a - b;
			mips_pkg::ALU_AND:    return a & b;
			mips_pkg::ALU_OR:     return a | b;
			mips_pkg::ALU_SLT:    return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
			mips_pkg::ALU_PASS_A: return a;
			default:              return 32'd0;
		endcase
	endfunction

	// operands of the issued instruction
	assign rs_val    = sregs[i_issue.rs_addr];
	assign rt_val    = sregs[i_issue.rt_addr];
	assign op_b      = i_issue.ctl.alu_src ? i_issue.imm : rt_val;
	assign exp_alu   = alu_model(i_issue.ctl.alu_op, rs_val, op_b);
	// word index from the byte address
	assign mem_ea    = rs_val + i_issue.imm;
	assign exp_word  = mem_ea[mips_pkg::DMEM_AW+1:2];
	assign exp_load  = smem[exp_word];
	assign br_equal  = (rs_val == rt_val);
	assign br_target = i_issue.pc_plus4 + (i_issue.imm * 32'd4);

	assign wr_issue = i_issue.ctl.regwrite && (i_issue.rd_addr != 5'd0);
	assign alu_wr   = wr_issue && !i_issue.ctl.memtoreg;
	assign load_wr  = wr_issue && i_issue.ctl.memtoreg;

	// reset plus two cycles after release
	assign reset_window = (low_edges != 0) && (!i_rst_n || post_edges < 2);

	always @(posedge i_clk)
	begin
		if (!i_rst_n)
		begin
			low_edges  <= low_edges + 1;
			post_edges <= 0;
			for (int i = 0; i < 32; i++)
			begin
				sregs[i] <= 32'd0;
			end
		end
		else
		begin
			if (post_edges < 2)
			begin
				post_edges <= post_edges + 1;
			end
			// follow the dut writeback, checked below
			if (o_wb_en && o_wb_addr != 5'd0)
			begin
				sregs[o_wb_addr] <= o_wb_data;
			end
			// stores land in the shadow at issue
			if (i_issue.ctl.memwrite)
			begin
				smem[exp_word] <= rt_val;
			end
		end
	end

	// ======================================
	// assertions
	// ======================================

	a_alu_wb: assert property (@(posedge i_clk) disable iff (!i_rst_n)
		alu_wr |-> ##2 (o_wb_en && o_wb_addr == $past(i_issue.rd_addr, 2)
			&& o_wb_data == $past(exp_alu, 2)))
	else
	begin
		error_count++;
		$error("Mismatch at %0t: alu writeback r%0d = %h", $time, o_wb_addr, o_wb_data);
	end

	a_load_wb: assert property (@(posedge i_clk) disable iff (!i_rst_n)
		load_wr |-> ##2 (o_wb_en && o_wb_addr == $past(i_issue.rd_addr, 2)
			&& o_wb_data == $past(exp_load, 2)))
	else
	begin
		error_count++;
		$error("Mismatch at %0t: load writeback r%0d = %h", $time, o_wb_addr, o_wb_data);
	end

	// no writeback without a matching issue, never to r0
	a_wb_only: assert property (@(posedge i_clk) disable iff (!i_rst_n)
		o_wb_en |-> (o_wb_addr != 5'd0 && $past(wr_issue, 2)))
	else
	begin
		error_count++;
		$error("writeback strobe at %0t without a matching register write", $time);
	end

	a_branch: assert property (@(posedge i_clk) disable iff (!i_rst_n)
		i_issue.ctl.branch |-> ##1 (o_pc_src == $past(br_equal)
			&& o_jb_pc == $past(br_target)))
	else
	begin
		error_count++;
		$error("Mismatch at %0t: branch pc_src %b target %h", $time, o_pc_src, o_jb_pc);
	end

	a_jumpreg: assert property (@(posedge i_clk) disable iff (!i_rst_n)
		i_issue.ctl.jumpreg |-> ##1 (o_pc_src && o_jb_pc == $past(rs_val)))
	else
	begin
		error_count++;
		$error("Mismatch at %0t: jump-register pc_src %b target %h", $time, o_pc_src, o_jb_pc);
	end

	a_pc_quiet: assert property (@(posedge i_clk) disable iff (!i_rst_n)
		o_pc_src |-> $past(i_issue.ctl.branch || i_issue.ctl.jumpreg))
	else
	begin
		error_count++;
		$error("pc source switched at %0t with no branch or jump-register issued", $time);
	end

	a_reset_quiet: assert property (@(posedge i_clk)
		reset_window |-> (!o_pc_src && !o_wb_en))
	else
	begin
		error_count++;
		$error("pc source or writeback active at %0t during or right after reset", $time);
	end

endmodule

//--- logic/mips_backend.sv
// ex, mem and wb stages of a MIPS pipeline; one instruction per cycle, no forwarding or stalls
`timescale 1ns/1ps

module mips_backend
(
	input  logic             i_clk,
	input  logic             i_rst_n,
	input  mips_pkg::id_ex_t i_issue,
	output logic             o_pc_src,
	output logic [31:0]      o_jb_pc,
	output logic             o_wb_en,
	output logic [4:0]       o_wb_addr,
	output logic [31:0]      o_wb_data
);

	// ======================================
	// wires
	// ======================================

	// register read values
	logic [31:0] rs_data;
	logic [31:0] rt_data;

	// pipeline registers
	mips_pkg::ex_mem_t ex_mem;
	mips_pkg::mem_wb_t mem_wb;

	// data memory bus
	logic [mips_pkg::DMEM_AW-1:0] mem_addr;
	logic [31:0]                  mem_wdata;
	logic                         mem_we;
	logic [31:0]                  mem_rdata;

	// ======================================
	// hierarchy
	// ======================================

	// read in the issue cycle, write from mem/wb
	reg_file u_reg_file
	(
		.i_clk     (i_clk),
		.i_rst_n   (i_rst_n),
		.i_rs_addr (i_issue.rs_addr),
		.i_rt_addr (i_issue.rt_addr),
		.i_mem_wb  (mem_wb),
		.o_rs_data (rs_data),
		.o_rt_data (rt_data),
		.o_wb_en   (o_wb_en),
		.o_wb_addr (o_wb_addr),
		.o_wb_data (o_wb_data)
	);

	ex_stage u_ex_stage
	(
		.i_clk     (i_clk),
		.i_rst_n   (i_rst_n),
		.i_issue   (i_issue),
		.i_rs_data (rs_data),
		.i_rt_data (rt_data),
		.o_ex_mem  (ex_mem)
	);

	// branch and jr resolve here
	mem_stage u_mem_stage
	(
		.i_clk       (i_clk),
		.i_rst_n     (i_rst_n),
		.i_ex_mem    (ex_mem),
		.i_mem_rdata (mem_rdata),
		.o_mem_addr  (mem_addr),
		.o_mem_wdata (mem_wdata),
		.o_mem_we    (mem_we),
		.o_pc_src    (o_pc_src),
		.o_jb_pc     (o_jb_pc),
		.o_mem_wb    (mem_wb)
	);

	data_memory u_data_memory
	(
		.i_clk   (i_clk),
		.i_addr  (mem_addr),
		.i_wdata (mem_wdata),
		.i_we    (mem_we),
		.o_rdata (mem_rdata)
	);

endmodule

//--- logic/reg_file.sv
// register file; no write-to-read bypass, so a result is visible one cycle after writeback
`timescale 1ns/1ps

module reg_file
(
	input  logic              i_clk,
	input  logic              i_rst_n,
	input  logic [4:0]        i_rs_addr,
	input  logic [4:0]        i_rt_addr,
	input  mips_pkg::mem_wb_t i_mem_wb,
	output logic [31:0]       o_rs_data,
	output logic [31:0]       o_rt_data,
	output logic              o_wb_en,
	output logic [4:0]        o_wb_addr,
	output logic [31:0]       o_wb_data
);

	// r0 has no storage
	logic [31:0] regs [1:31];

	logic        wb_en;
	logic [31:0] wb_data;

	// ======================================
	// writeback select
	// ======================================

	// load data or alu result
	assign wb_data = i_mem_wb.memtoreg ? i_mem_wb.mem_data : i_mem_wb.alu_result;

	// writes to r0 are dropped
	assign wb_en = i_mem_wb.regwrite & (i_mem_wb.dest != 5'd0);

	assign o_wb_en   = wb_en;
	assign o_wb_addr = i_mem_wb.dest;
	assign o_wb_data = wb_data;

	// ======================================
	// register write
	// ======================================

	always_ff @(posedge i_clk)
	begin
		if (!i_rst_n)
		begin
			for (int i = 1; i < 32; i++)
			begin
				regs[i] <= 32'd0;
			end
		end
		else if (wb_en)
		begin
			regs[i_mem_wb.dest] <= wb_data;
		end
	end

	// ======================================
	// read ports
	// ======================================

	// r0 always reads zero
	assign o_rs_data = (i_rs_addr == 5'd0) ? 32'd0 : regs[i_rs_addr];
	assign o_rt_data = (i_rt_addr == 5'd0) ? 32'd0 : regs[i_rt_addr];

endmodule

//--- memory/data_memory.sv
// data RAM; contents are undefined until written, and there is no reset
`timescale 1ns/1ps

module data_memory
(
	input  logic                         i_clk,
	input  logic [mips_pkg::DMEM_AW-1:0] i_addr,
	input  logic [31:0]                  i_wdata,
	input  logic                         i_we,
	output logic [31:0]                  o_rdata
);

	// ======================================
	// storage
	// ======================================

	// one 32-bit word per entry
	logic [31:0] mem [mips_pkg::DMEM_WORDS];

	// ======================================
	// read port
	// ======================================

	// asynchronous, load data ready in the same cycle
	assign o_rdata = mem[i_addr];

	// ======================================
	// write port
	// ======================================

	// store lands at the end of the mem cycle
	always_ff @(posedge i_clk)
	begin
		if (i_we)
		begin
			mem[i_addr] <= i_wdata;
		end
	end

	// a read of the word being written
	// still returns the old contents

endmodule

//--- memory/mem_stage.sv
// memory stage; word accesses only, and the address wraps to the data memory depth
`timescale 1ns/1ps

module mem_stage
(
	input  logic                         i_clk,
	input  logic                         i_rst_n,
	input  mips_pkg::ex_mem_t            i_ex_mem,
	input  logic [31:0]                  i_mem_rdata,
	output logic [mips_pkg::DMEM_AW-1:0] o_mem_addr,
	output logic [31:0]                  o_mem_wdata,
	output logic                         o_mem_we,
	output logic                         o_pc_src,
	output logic [31:0]                  o_jb_pc,
	output mips_pkg::mem_wb_t            o_mem_wb
);

	mips_pkg::mem_wb_t mem_wb_next;
	mips_pkg::mem_wb_t mem_wb_q;

	// ======================================
	// data memory access
	// ======================================

	// drop the byte offset
	assign o_mem_addr  = i_ex_mem.alu_result[mips_pkg::DMEM_AW+1:2];
	assign o_mem_wdata = i_ex_mem.store_data;
	assign o_mem_we    = i_ex_mem.ctl.memwrite;

	// ======================================
	// pc source and target
	// ======================================

	// taken beq or any jr
	assign o_pc_src = (i_ex_mem.ctl.branch & i_ex_mem.zero) | i_ex_mem.ctl.jumpreg;

	// jr target is rs, carried in alu_result
	assign o_jb_pc = i_ex_mem.ctl.jumpreg ? i_ex_mem.alu_result : i_ex_mem.branch_target;

	// ======================================
	// mem/wb register
	// ======================================

	always_comb
	begin
		mem_wb_next.regwrite   = i_ex_mem.ctl.regwrite;
		mem_wb_next.memtoreg   = i_ex_mem.ctl.memtoreg;
		// load word captured only on a read
		mem_wb_next.mem_data   = i_ex_mem.ctl.memread ? i_mem_rdata : 32'd0;
		mem_wb_next.alu_result = i_ex_mem.alu_result;
		mem_wb_next.dest       = i_ex_mem.dest;
	end

	always_ff @(posedge i_clk)
	begin
		mem_wb_q <= mem_wb_next;
		// writeback controls low out of reset
		if (!i_rst_n)
		begin
			mem_wb_q.regwrite <= 1'b0;
			mem_wb_q.memtoreg <= 1'b0;
		end
	end

	assign o_mem_wb = mem_wb_q;

endmodule

//--- execute/ex_stage.sv
// execute stage; operands arrive unforwarded, and the destination must already be chosen by decode
`timescale 1ns/1ps

module ex_stage
(
	input  logic              i_clk,
	input  logic              i_rst_n,
	input  mips_pkg::id_ex_t  i_issue,
	input  logic [31:0]       i_rs_data,
	input  logic [31:0]       i_rt_data,
	output mips_pkg::ex_mem_t o_ex_mem
);

	// ======================================
	// operands
	// ======================================

	logic [31:0] op_a;
	logic [31:0] op_b;
	logic [31:0] alu_result;
	logic        alu_zero;
	logic [31:0] branch_target;

	mips_pkg::ex_mem_t ex_mem_next;
	mips_pkg::ex_mem_t ex_mem_q;

	// a is always rs
	assign op_a = i_rs_data;

	// b is the immediate for i-type, rt otherwise
	assign op_b = i_issue.ctl.alu_src ? i_issue.imm : i_rt_data;

	// ======================================
	// alu
	// ======================================

	always_comb
	begin
		case (i_issue.ctl.alu_op)
			mips_pkg::ALU_ADD:
				alu_result = op_a + op_b;
			mips_pkg::ALU_SUB:
				alu_result = op_a - op_b;
			mips_pkg::ALU_AND:
				alu_result = op_a & op_b;
			mips_pkg::ALU_OR:
				alu_result = op_a | op_b;
			// signed compare
			mips_pkg::ALU_SLT:
				alu_result = {31'd0, $signed(op_a) < $signed(op_b)};
			// jr target rides the result bus
			mips_pkg::ALU_PASS_A:
				alu_result = op_a;
			default:
				alu_result = '0;
		endcase
	end

	// beq compares through a subtract
	assign alu_zero = (alu_result == 32'd0);

	// word offset from pc+4
	assign branch_target = i_issue.pc_plus4 + {i_issue.imm[29:0], 2'b00};

	// ======================================
	// ex/mem register
	// ======================================

	always_comb
	begin
		ex_mem_next.ctl           = i_issue.ctl;
		ex_mem_next.zero          = alu_zero;
		ex_mem_next.alu_result    = alu_result;
		// rt is the store payload
		ex_mem_next.store_data    = i_rt_data;
		ex_mem_next.branch_target = branch_target;
		ex_mem_next.dest          = i_issue.rd_addr;
	end

	always_ff @(posedge i_clk)
	begin
		ex_mem_q <= ex_mem_next;
		// only control is cleared, so a reset reads as a bubble
		if (!i_rst_n)
		begin
			ex_mem_q.ctl <= '0;
		end
	end

	assign o_ex_mem = ex_mem_q;

endmodule

//--- common/mips_pkg.sv
// shared types for the back-end pipeline; no hazard logic exists, so the issuer must space dependent instructions
package mips_pkg;

	// ======================================
	// sizes
	// ======================================

	// data memory depth in 32-bit words
	localparam int DMEM_WORDS = 64;
	// word address width, taken from byte address bits above the byte offset
	localparam int DMEM_AW = 6;

	// ======================================
	// alu functions
	// ======================================

	typedef enum logic [2:0]
	{
		ALU_ADD    = 3'd0,
		ALU_SUB    = 3'd1,
		ALU_AND    = 3'd2,
		ALU_OR     = 3'd3,
		ALU_SLT    = 3'd4,
		// rs straight through, used by jump-register
		ALU_PASS_A = 3'd5
	} alu_op_e;

	// ======================================
	// control and pipeline registers
	// ======================================

	// per-instruction control, all zero is a bubble
	typedef struct packed
	{
		logic    regwrite;
		logic    memtoreg;
		logic    memread;
		logic    memwrite;
		logic    branch;
		logic    jumpreg;
		logic    alu_src;
		alu_op_e alu_op;
	} ctl_t;

	// issued instruction from decode
	typedef struct packed
	{
		ctl_t        ctl;
		logic [4:0]  rs_addr;
		logic [4:0]  rt_addr;
		// destination as resolved by decode
		logic [4:0]  rd_addr;
		logic [31:0] imm;
		logic [31:0] pc_plus4;
	} id_ex_t;

	// ex/mem register
	typedef struct packed
	{
		ctl_t        ctl;
		logic        zero;
		logic [31:0] alu_result;
		logic [31:0] store_data;
		logic [31:0] branch_target;
		logic [4:0]  dest;
	} ex_mem_t;

	// mem/wb register
	typedef struct packed
	{
		logic        regwrite;
		logic        memtoreg;
		logic [31:0] mem_data;
		logic [31:0] alu_result;
		logic [4:0]  dest;
	} mem_wb_t;

endpackage
